/* Makefile */
# Verilator flow for the ROM integrity checker

VERILATOR ?= verilator
TOP       ?= tb_rom_check
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* hdl/rom_check_cfg_pkg.sv */
`default_nettype none

package rom_check_cfg_pkg;

  // Multi-bit boolean, four bits wide
  // Only the two values below are legal, anything else reads as a fault
  typedef logic [3:0] mubi4_t;

  // Check passed
  localparam mubi4_t MuBi4True = 4'h6;

  // Check failed or not finished yet
  localparam mubi4_t MuBi4False = 4'h9;

  // Left rotate applied to a lane before each word is added
  localparam int unsigned DigestRot = 5;

  // Every lane starts from this value after reset
  localparam logic [31:0] LaneInit = 32'h0000_0000;

  // Lane update is: rotl(lane, DigestRot) + word, then xor address
  // Not a cryptographic hash, only catches simple corruption

endpackage

`default_nettype wire

/* hdl/rom_check_state_pkg.sv */
`default_nettype none

package rom_check_state_pkg;

  // Scan stage FSM
  // Idle until start, Reading while requests go out, then Finished for good
  typedef enum logic [1:0] {
    Idle     = 2'b00,
    Reading  = 2'b01,
    Finished = 2'b10
  } scan_state_e;

  // Compare stage FSM
  // Waiting for the computed digest, Checking one word per cycle, then Done
  typedef enum logic [1:0] {
    Waiting  = 2'b00,
    Checking = 2'b01,
    Done     = 2'b10
  } cmp_state_e;

endpackage

`default_nettype wire

/* hdl/rom_check_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_check_top #(
  parameter int unsigned NumRomWords    = 16,
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           start_i,
  output logic [$clog2(NumRomWords)-1:0] rom_addr_o,
  output logic                           rom_req_o,
  input  logic [31:0]                    rom_data_i,
  output logic                           done_o,
  output rom_check_cfg_pkg::mubi4_t      good_o,
  output logic                           alert_o
);

  localparam int unsigned AddrW = $clog2(NumRomWords);

  // Scan to digest
  logic                         data_valid;
  logic                         data_last;
  logic [31:0]                  data;
  logic [AddrW-1:0]             data_addr;
  // Scan to compare
  logic [NumDigestWords*32-1:0] exp_digest;
  logic                         scan_done;
  logic                         start_alert;
  // Digest to compare
  logic [NumDigestWords*32-1:0] digest;
  logic                         digest_done;
  logic                         ext_alert;

  // Compare finishing ahead of the scan means the stages fell out of step
  assign ext_alert = start_alert | (done_o & ~scan_done);

  rom_scan #(
    .NumRomWords    (NumRomWords),
    .NumDigestWords (NumDigestWords)
  ) u_rom_scan (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .rom_addr_o    (rom_addr_o),
    .rom_req_o     (rom_req_o),
    .rom_data_i    (rom_data_i),
    .data_valid_o  (data_valid),
    .data_last_o   (data_last),
    .data_o        (data),
    .data_addr_o   (data_addr),
    .exp_digest_o  (exp_digest),
    .scan_done_o   (scan_done),
    .start_alert_o (start_alert)
  );

  rom_digest #(
    .NumRomWords    (NumRomWords),
    .NumDigestWords (NumDigestWords)
  ) u_rom_digest (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_valid_i  (data_valid),
    .data_last_i   (data_last),
    .data_i        (data),
    .data_addr_i   (data_addr),
    .digest_o      (digest),
    .digest_done_o (digest_done)
  );

  rom_compare #(
    .NumDigestWords (NumDigestWords)
  ) u_rom_compare (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (digest_done),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .ext_alert_i  (ext_alert),
    .done_o       (done_o),
    .good_o       (good_o),
    .alert_o      (alert_o)
  );

endmodule

`default_nettype wire

/* hdl/rom_compare.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_compare #(
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  logic [NumDigestWords*32-1:0] digest_i,
  input  logic [NumDigestWords*32-1:0] exp_digest_i,
  input  logic                         ext_alert_i,
  output logic                         done_o,
  output rom_check_cfg_pkg::mubi4_t    good_o,
  output logic                         alert_o
);

  import rom_check_cfg_pkg::*;
  import rom_check_state_pkg::*;

  localparam int unsigned IdxW = (NumDigestWords > 1) ? $clog2(NumDigestWords) : 1;
  localparam logic [IdxW-1:0] LastIdx = IdxW'(NumDigestWords - 1);

  cmp_state_e      state_q, state_d;
  logic [IdxW-1:0] idx_q;
  logic            idx_incr;
  logic            matches_q;
  logic            alert_q;
  logic            fsm_alert;
  logic            start_alert;
  logic            wait_idx_alert;
  logic            done_idx_alert;
  logic [IdxW+4:0] word_lsb;
  logic [31:0]     digest_word;
  logic [31:0]     exp_digest_word;

  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    unique case (state_q)
      Waiting: begin
        if (start_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        // Last word compared this cycle
        if (idx_q == LastIdx) begin
          state_d = Done;
        end
      end
      Done: begin
        // Final, only reset leaves
      end
      default: fsm_alert = 1'b1;
    endcase
  end

  // Consistency checks on control flow and the index
  assign start_alert    = start_i && (state_q != Waiting);
  assign wait_idx_alert = (state_q == Waiting) && (idx_q != '0);
  assign done_idx_alert = (state_q == Done) && (idx_q != LastIdx);

  // Index stops on the last word so it never wraps
  assign idx_incr = (state_q == Checking) && (idx_q != LastIdx);

  // Word select, 32 bits per index step
  assign word_lsb        = {idx_q, 5'd0};
  assign digest_word     = digest_i[word_lsb +: 32];
  assign exp_digest_word = exp_digest_i[word_lsb +: 32];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Waiting;
      idx_q     <= '0;
      matches_q <= 1'b1;
      alert_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (idx_incr) begin
        idx_q <= idx_q + 1'b1;
      end
      // Any mismatching word clears it for good
      if (state_q == Checking) begin
        matches_q <= matches_q && (digest_word == exp_digest_word);
      end
      // Sticky until reset
      alert_q <= alert_q | fsm_alert | start_alert | wait_idx_alert |
                 done_idx_alert | ext_alert_i;
    end
  end

  assign done_o = (state_q == Done);

  // Good only once Done and every word matched
  assign good_o = (done_o && matches_q) ? MuBi4True : MuBi4False;

  assign alert_o = alert_q;

endmodule

`default_nettype wire

/* hdl/rom_digest.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_digest #(
  parameter int unsigned NumRomWords    = 16,
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           data_valid_i,
  input  logic                           data_last_i,
  input  logic [31:0]                    data_i,
  input  logic [$clog2(NumRomWords)-1:0] data_addr_i,
  output logic [NumDigestWords*32-1:0]   digest_o,
  output logic                           digest_done_o
);

  import rom_check_cfg_pkg::*;

  localparam int unsigned AddrW = $clog2(NumRomWords);

  logic [AddrW-1:0] lane_sel;
  logic [31:0]      lane_q [NumDigestWords];
  logic             digest_done_q;

  // One fold step: rotate left, add the word, xor in the address
  function automatic logic [31:0] fold_step(
    input logic [31:0]      lane,
    input logic [31:0]      word,
    input logic [AddrW-1:0] addr
  );
    logic [31:0] rotated;
    rotated = (lane << DigestRot) | (lane >> (32 - DigestRot));
    return (rotated + word) ^ 32'(addr);
  endfunction

  // Address modulo lane count picks the lane
  assign lane_sel = data_addr_i % AddrW'(NumDigestWords);

  for (genvar k = 0; k < NumDigestWords; k++) begin : g_lane
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        lane_q[k] <= LaneInit;
      end else if (data_valid_i && (lane_sel == AddrW'(k))) begin
        lane_q[k] <= fold_step(lane_q[k], data_i, data_addr_i);
      end
    end
    assign digest_o[k*32 +: 32] = lane_q[k];
  end

  // Last word folded in on the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_done_q <= 1'b0;
    end else begin
      digest_done_q <= data_valid_i && data_last_i;
    end
  end

  assign digest_done_o = digest_done_q;

endmodule

`default_nettype wire

/* hdl/rom_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_scan #(
  parameter int unsigned NumRomWords    = 16,
  parameter int unsigned NumDigestWords = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  output logic [$clog2(NumRomWords)-1:0]   rom_addr_o,
  output logic                             rom_req_o,
  input  logic [31:0]                      rom_data_i,
  output logic                             data_valid_o,
  output logic                             data_last_o,
  output logic [31:0]                      data_o,
  output logic [$clog2(NumRomWords)-1:0]   data_addr_o,
  output logic [NumDigestWords*32-1:0]     exp_digest_o,
  output logic                             scan_done_o,
  output logic                             start_alert_o
);

  import rom_check_state_pkg::*;

  localparam int unsigned AddrW     = $clog2(NumRomWords);
  localparam int unsigned DataWords = NumRomWords - NumDigestWords;

  // Address landmarks
  localparam logic [AddrW-1:0] LastAddr = AddrW'(NumRomWords - 1);
  localparam logic [AddrW-1:0] LastData = AddrW'(DataWords - 1);
  localparam logic [AddrW-1:0] FirstExp = AddrW'(DataWords);

  scan_state_e      state_q, state_d;
  logic [AddrW-1:0] addr_q;
  // Request delayed by one cycle, lines up with rom_data_i
  logic             rsp_valid_q;
  logic [AddrW-1:0] rsp_addr_q;
  logic [31:0]      exp_word_q [NumDigestWords];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (start_i) begin
          state_d = Reading;
        end
      end
      Reading: begin
        // Last request goes out this cycle
        if (addr_q == LastAddr) begin
          state_d = Finished;
        end
      end
      Finished: begin
        // Final, only reset leaves
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      addr_q      <= '0;
      rsp_valid_q <= 1'b0;
      rsp_addr_q  <= '0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= rom_req_o;
      rsp_addr_q  <= addr_q;
      // Counter parks on the top address
      if (rom_req_o && (addr_q != LastAddr)) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign rom_req_o  = (state_q == Reading);
  assign rom_addr_o = addr_q;

  // Low words go on to the digest stage
  assign data_valid_o = rsp_valid_q && (rsp_addr_q < FirstExp);
  assign data_last_o  = rsp_valid_q && (rsp_addr_q == LastData);
  assign data_o       = rom_data_i;
  assign data_addr_o  = rsp_addr_q;

  // Top words are the stored digest, one slot each
  for (genvar i = 0; i < NumDigestWords; i++) begin : g_exp_word
    localparam logic [AddrW-1:0] WordAddr = AddrW'(DataWords + i);
    always_ff @(posedge clk_i) begin
      if (rsp_valid_q && (rsp_addr_q == WordAddr)) begin
        exp_word_q[i] <= rom_data_i;
      end
    end
    // Word 0 in the low bits
    assign exp_digest_o[i*32 +: 32] = exp_word_q[i];
  end

  // Last response has landed
  assign scan_done_o = (state_q == Finished) && !rsp_valid_q;

  // Start while busy or finished is ignored but flagged
  assign start_alert_o = start_i && (state_q != Idle);

endmodule

`default_nettype wire

/* testbench/rom_check_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module rom_check_sva #(
  parameter int unsigned NumDigestWords = 2
) (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      checking_i,
  input logic                      done_i,
  input rom_check_cfg_pkg::mubi4_t good_i
);

  import rom_check_cfg_pkg::*;

  localparam int unsigned CntW = $clog2(NumDigestWords + 1);

  // Cycles spent in Checking before the current one
  logic [CntW-1:0] chk_cycles_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chk_cycles_q <= '0;
    end else if (checking_i) begin
      chk_cycles_q <= chk_cycles_q + CntW'(1);
    end else begin
      chk_cycles_q <= '0;
    end
  end

  // Only the two legal mubi values ever leave the block
  good_legal_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (good_i == MuBi4True) || (good_i == MuBi4False))
    else $error("good_o holds an illegal value %h", good_i);

  // Done is final
  done_held_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> done_i)
    else $error("done_o fell without a reset");

  // Never more than one cycle per digest word
  checking_max_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    checking_i |-> (chk_cycles_q < CntW'(NumDigestWords)))
    else $error("compare stage stayed in Checking too long");

  // And never fewer
  checking_len_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(checking_i) |-> ($past(chk_cycles_q) == CntW'(NumDigestWords - 1)))
    else $error("compare stage left Checking early");

endmodule

`default_nettype wire

/* testbench/rom_check_trace.txt */
# Header columns: test name, expected good_o in hex (6 true, 9 false), second start flag
# Then 16 ROM words in hex, four per line, address 0 first; words 14 and 15 are the stored digest
# Data words are 1 to 14, fold gives lane 0 = 42108421 and lane 1 = ce378ce3

# Stored digest matches the fold
match 6 0
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000009 0000000a 0000000b 0000000c
0000000d 0000000e 42108421 ce378ce3

# Last stored digest word off by one
bad_exp_word 9 0
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000009 0000000a 0000000b 0000000c
0000000d 0000000e 42108421 ce378ce2

# Data word at address 0 corrupted
bad_data_word 9 0
00000000 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000009 0000000a 0000000b 0000000c
0000000d 0000000e 42108421 ce378ce3

# Good image, second start during the scan raises the alert
second_start 6 1
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000009 0000000a 0000000b 0000000c
0000000d 0000000e 42108421 ce378ce3

/* testbench/tb_rom_check.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rom_check;

  import rom_check_cfg_pkg::*;

  localparam int    NumRomWords    = 16;
  localparam int    NumDigestWords = 2;
  localparam int    AddrW          = $clog2(NumRomWords);
  localparam int    MaxTests       = 8;
  localparam int    WordsPerLine   = 4;
  localparam string TracePath      = "testbench/rom_check_trace.txt";

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             start_i;
  logic [AddrW-1:0] rom_addr_o;
  logic             rom_req_o;
  logic [31:0]      rom_data_i = '0;
  logic             done_o;
  mubi4_t           good_o;
  logic             alert_o;

  // ROM image of the running test
  logic [31:0]      rom_mem [NumRomWords];
  logic             req_seen;
  logic [AddrW-1:0] addr_seen;
  int               req_count = 0;
  int               addr_errors = 0;

  // Tests as read from the trace
  string       test_name    [MaxTests];
  logic [31:0] test_rom     [MaxTests][NumRomWords];
  mubi4_t      test_good    [MaxTests];
  logic        test_restart [MaxTests];
  int          num_tests    = 0;

  int errors       = 0;
  int tests_passed = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;

  always #10 clk_i = ~clk_i;

  rom_check_top #(
    .NumRomWords    (NumRomWords),
    .NumDigestWords (NumDigestWords)
  ) rom_check_top_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .rom_addr_o (rom_addr_o),
    .rom_req_o  (rom_req_o),
    .rom_data_i (rom_data_i),
    .done_o     (done_o),
    .good_o     (good_o),
    .alert_o    (alert_o)
  );

  bind rom_compare rom_check_sva #(
    .NumDigestWords (NumDigestWords)
  ) u_rom_check_sva (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .checking_i (state_q == rom_check_state_pkg::Checking),
    .done_i     (done_o),
    .good_i     (good_o)
  );

  // ROM model answers one cycle after the request
  always begin
    @(negedge clk_i);
    req_seen  = rom_req_o;
    addr_seen = rom_addr_o;
    if (!rst_ni) begin
      req_count   = 0;
      addr_errors = 0;
    end else if (req_seen) begin
      // Requests walk the ROM from address 0 upward
      if (int'(addr_seen) != req_count) begin
        addr_errors = addr_errors + 1;
      end
      req_count = req_count + 1;
    end
    @(posedge clk_i);
    #2;
    if (req_seen) begin
      rom_data_i = rom_mem[addr_seen];
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("Timeout: no result after %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
    errors++;
  endtask

  // Next data line of the trace
  // Comment lines and blank lines are skipped
  function automatic bit read_data_line(input int fd, output string line);
    int  n;
    byte c;
    line = "";
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        c = line.getc(0);
        if ((c != "#") && (c != 8'h0a) && (c != 8'h0d)) begin
          return 1'b1;
        end
      end
    end
    return 1'b0;
  endfunction

  task automatic load_trace();
    int          fd;
    int          n;
    int          row;
    int          col;
    int          good_val;
    int          flag_val;
    bit          ok;
    string       line;
    string       name;
    logic [31:0] w [WordsPerLine];
    fd = $fopen(TracePath, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TracePath);
      errors++;
      return;
    end
    ok = 1'b1;
    while (ok && (num_tests < MaxTests) && read_data_line(fd, line)) begin
      // Header holds name, expected good and the second start flag
      n = $sscanf(line, "%s %h %d", name, good_val, flag_val);
      if (n != 3) begin
        $display("Malformed test header in the trace: %s", line);
        ok = 1'b0;
      end
      for (row = 0; ok && (row < NumRomWords / WordsPerLine); row++) begin
        if (!read_data_line(fd, line)) begin
          $display("Trace ends inside the ROM image of %s", name);
          ok = 1'b0;
        end else begin
          n = $sscanf(line, "%h %h %h %h", w[0], w[1], w[2], w[3]);
          if (n != WordsPerLine) begin
            $display("Malformed ROM line in test %s: %s", name, line);
            ok = 1'b0;
          end else begin
            for (col = 0; col < WordsPerLine; col++) begin
              test_rom[num_tests][row * WordsPerLine + col] = w[col];
            end
          end
        end
      end
      if (ok) begin
        test_name[num_tests]    = name;
        test_good[num_tests]    = good_val[3:0];
        test_restart[num_tests] = (flag_val != 0);
        num_tests++;
      end
    end
    $fclose(fd);
    if (!ok) begin
      errors++;
    end
    if (num_tests == 0) begin
      $display("No tests found in the trace");
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #2;
    rst_ni  = 1'b0;
    start_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
  endtask

  task automatic pulse_start();
    @(posedge clk_i);
    #2;
    start_i = 1'b1;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
  endtask

  task automatic run_test(input int t);
    int     errs_before;
    int     i;
    string  name;
    logic   exp_alert;
    mubi4_t exp_good;
    errs_before = errors;
    name        = test_name[t];
    exp_alert   = test_restart[t];
    exp_good    = test_good[t];
    for (i = 0; i < NumRomWords; i++) begin
      rom_mem[i] = test_rom[t][i];
    end
    apply_reset();

    // Idle outputs straight out of reset
    @(negedge clk_i);
    if (done_o !== 1'b0) report_mismatch(name, "done_o after reset", 32'h0, 32'(done_o));
    if (alert_o !== 1'b0) report_mismatch(name, "alert_o after reset", 32'h0, 32'(alert_o));
    if (good_o !== MuBi4False) begin
      report_mismatch(name, "good_o after reset", 32'(MuBi4False), 32'(good_o));
    end

    pulse_start();
    if (test_restart[t]) begin
      // Scan is well inside Reading here
      repeat (2) @(posedge clk_i);
      pulse_start();
    end

    while (done_o !== 1'b1) @(negedge clk_i);
    if (good_o !== exp_good) report_mismatch(name, "good_o", 32'(exp_good), 32'(good_o));
    if (alert_o !== exp_alert) report_mismatch(name, "alert_o", 32'(exp_alert), 32'(alert_o));
    if (req_count != NumRomWords) begin
      report_mismatch(name, "ROM reads", 32'(NumRomWords), 32'(req_count));
    end
    if (addr_errors != 0) begin
      report_mismatch(name, "out of order ROM addresses", 32'h0, 32'(addr_errors));
    end

    // Results hold until the next reset
    repeat (3) @(negedge clk_i);
    if (done_o !== 1'b1) report_mismatch(name, "done_o held", 32'h1, 32'(done_o));
    if (good_o !== exp_good) report_mismatch(name, "good_o held", 32'(exp_good), 32'(good_o));
    if (alert_o !== exp_alert) begin
      report_mismatch(name, "alert_o held", 32'(exp_alert), 32'(alert_o));
    end

    if (errors == errs_before) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int t;
    rst_ni  = 1'b0;
    start_i = 1'b0;
    load_trace();
    cycle_limit = num_tests * (NumRomWords + NumDigestWords + 20);
    for (t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             num_tests, tests_passed, num_tests - tests_passed, errors);
    if ((errors == 0) && (num_tests > 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hdl/rom_check_cfg_pkg.sv
hdl/rom_check_state_pkg.sv
hdl/rom_scan.sv
hdl/rom_digest.sv
hdl/rom_compare.sv
hdl/rom_check_top.sv
testbench/rom_check_sva.sv
testbench/tb_rom_check.sv
